//--- proj.f
+incdir+common
common/proj_pkg.sv
common/screen_pt_if.sv
fp16/fp16_div.sv
fp16/fp16_mul.sv
hdl/z_divide.sv
hdl/vertex_project.sv
hdl/viewport_map.sv
hdl/proj_top.sv
tb/proj_asserts.sv
tb/proj_tb.sv

//--- tb/proj_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "proj_config.svh"

module proj_tb;
  import proj_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int TOTAL_LAT    = `PROJ_DIV_LAT + `PROJ_MUL_LAT + `PROJ_VP_LAT;
  localparam int W_LOG2       = `PROJ_SCREEN_W_LOG2;
  localparam int H_LOG2       = `PROJ_SCREEN_H_LOG2;
  localparam int IDLE_TIMEOUT = 1000;  // cycles allowed for the pipe to drain
  localparam int N_PHASES     = 8;
  localparam int PHASE_CYCLES = 60;

  // one expected pixel stamped with the drive time
  typedef struct packed {
    logic [W_LOG2-1:0] px;
    logic [H_LOG2-1:0] py;
    logic              off;
    logic              behind;
    logic [63:0]       stamp;
  } expect_t;

  logic              clk;
  logic              arst_n;
  f16                cam_near_clip;
  logic              vertex_valid;
  vec3_f16           vertex;
  logic              pixel_valid;
  logic [W_LOG2-1:0] pixel_x;
  logic [H_LOG2-1:0] pixel_y;
  logic              off_screen;
  logic              behind;

  expect_t exp_q[$];    // model results in input order
  f16      near_val;    // mirror of cam_near_clip for the model
  int      error_count;
  int      check_count;

  proj_top i_dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .cam_near_clip (cam_near_clip),
    .vertex_valid  (vertex_valid),
    .vertex        (vertex),
    .pixel_valid   (pixel_valid),
    .pixel_x       (pixel_x),
    .pixel_y       (pixel_y),
    .off_screen    (off_screen),
    .behind        (behind)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("mismatch %s: expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
    end
  endtask

  // e <= 0 flushes and e >= 31 saturates to inf
  function automatic f16 pack_f16(input logic s, input int e, input int sig);
    f16 r;
    r.bits        = '0;
    r.fields.sign = s;
    if (e >= 31) begin
      r.fields.exp = 5'h1f;
    end else if (e > 0) begin
      r.fields.exp  = e[4:0];
      r.fields.mant = sig[9:0];  // hidden one dropped
    end
    return r;
  endfunction

  function automatic f16 model_div(input f16 a, input f16 b);
    int   ma;
    int   mb;
    int   e;
    int   sig;
    logic s;
    s = a.fields.sign ^ b.fields.sign;
    if (b.fields.exp == 5'd0) begin
      return pack_f16(s, 31, 0);  // divide by zero
    end
    if (a.fields.exp == 5'd0) begin
      return pack_f16(s, 0, 0);
    end
    ma = 1024 + int'(a.fields.mant);
    mb = 1024 + int'(b.fields.mant);
    e  = int'(a.fields.exp) - int'(b.fields.exp) + 15;
    if (ma >= mb) begin
      sig = (ma * 1024) / mb;  // truncated quotient
    end else begin
      sig = (ma * 2048) / mb;
      e   = e - 1;
    end
    return pack_f16(s, e, sig);
  endfunction

  function automatic f16 model_mul(input f16 a, input f16 b);
    int   prod;
    int   e;
    logic s;
    s = a.fields.sign ^ b.fields.sign;
    if (a.fields.exp == 5'd0 || b.fields.exp == 5'd0) begin
      return pack_f16(s, 0, 0);
    end
    prod = (1024 + int'(a.fields.mant)) * (1024 + int'(b.fields.mant));
    e    = int'(a.fields.exp) + int'(b.fields.exp) - 15;
    if (prod >= (1 << 21)) begin
      return pack_f16(s, e + 1, prod >> 11);
    end
    return pack_f16(s, e, prod >> 10);
  endfunction

  // floor(c * 2^(lg-1)) + 2^(lg-1) clamped to the screen with off set when clamped
  function automatic int model_axis(input f16 c, input int lg, output logic off);
    longint sig;
    longint q;
    longint scaled;
    longint pix;
    longint top;
    int     k;
    top = (longint'(1) << lg) - 1;
    if (c.fields.exp == 5'd0) begin
      scaled = 0;
    end else begin
      sig = 1024 + longint'(c.fields.mant);
      k   = 26 - lg - int'(c.fields.exp);  // c = sig * 2^(exp-25)
      if (k <= 0) begin
        q      = sig << (-k);
        scaled = c.fields.sign ? -q : q;
      end else begin
        q = sig >> k;
        if (c.fields.sign) begin
          scaled = ((q << k) == sig) ? -q : -(q + 1);  // round toward -inf
        end else begin
          scaled = q;
        end
      end
    end
    pix = scaled + (top + 1) / 2;
    off = (pix < 0) || (pix > top);
    if (pix < 0) begin
      pix = 0;
    end else if (pix > top) begin
      pix = top;
    end
    return int'(pix);
  endfunction

  function automatic expect_t model_vertex(input vec3_f16 v, input f16 near);
    expect_t e;
    f16      neg_z;
    f16      sx;
    f16      sy;
    logic    ox;
    logic    oy;
    int      px;
    int      py;
    neg_z             = v[2];
    neg_z.fields.sign = ~v[2].fields.sign;  // camera looks down -z
    sx       = model_mul(model_div(v[0], neg_z), near);
    sy       = model_mul(model_div(v[1], neg_z), near);
    px       = model_axis(sx, W_LOG2, ox);
    py       = model_axis(sy, H_LOG2, oy);
    e.px     = px[W_LOG2-1:0];
    e.py     = py[H_LOG2-1:0];
    e.off    = ox | oy;
    e.behind = !v[2].fields.sign || (v[2].fields.exp == 5'd0);
    e.stamp  = '0;
    return e;
  endfunction

  // mostly exp 12..17 plus zeros, subnormals and large values
  function automatic f16 rand_f16();
    f16 r;
    int kind;
    kind          = $urandom % 16;
    r.fields.sign = $urandom % 2;
    r.fields.mant = 10'($urandom % 1024);
    if (kind == 0) begin
      r.fields.exp  = 5'd0;
      r.fields.mant = 10'd0;
    end else if (kind == 1) begin
      r.fields.exp  = 5'd0;
      r.fields.mant = 10'(1 + $urandom % 1023);  // subnormal
    end else if (kind == 2) begin
      r.fields.exp = 5'(25 + $urandom % 6);
    end else begin
      r.fields.exp = 5'(12 + $urandom % 6);
    end
    return r;
  endfunction

  task automatic drive_phase(input int n_cycles, input bit full_rate);
    vec3_f16 v;
    expect_t e;
    logic    go;
    for (int i = 0; i < n_cycles; i++) begin
      @(posedge clk);
      go   = full_rate ? 1'b1 : (($urandom % 4) != 0);  // 3 of 4 otherwise
      v[0] = rand_f16();
      v[1] = rand_f16();
      v[2] = rand_f16();
      vertex_valid <= go;
      vertex       <= v;
      if (go) begin
        e       = model_vertex(v, near_val);
        e.stamp = $time;
        exp_q.push_back(e);
      end
    end
    @(posedge clk);
    vertex_valid <= 1'b0;
  endtask

  task automatic wait_idle(output bit ok);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < IDLE_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    ok = (exp_q.size() == 0);
    if (!ok) begin
      error_count++;
      $display("error: outputs missing, %0d vertices got no pixel within %0d cycles",
               exp_q.size(), IDLE_TIMEOUT);
    end
  endtask

  // outputs settle after the rising edge so sample on the falling one
  always @(negedge clk) begin : pixel_monitor
    expect_t e;
    if (arst_n && pixel_valid) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("error: pixel_valid at %0t with no vertex in flight", $time);
      end else begin
        e = exp_q.pop_front();
        check_value("pixel_x", e.px, pixel_x);
        check_value("pixel_y", e.py, pixel_y);
        check_value("off_screen", e.off, off_screen);
        check_value("behind", e.behind, behind);
        check_value("latency", TOTAL_LAT, ($time - CLK_PERIOD / 2 - e.stamp) / CLK_PERIOD);
      end
    end
  end

  initial begin
    bit ok;
    void'($urandom(28940));
    error_count   = 0;
    check_count   = 0;
    arst_n        = 1'b0;
    vertex_valid  = 1'b0;
    vertex        = '0;
    near_val.bits = 16'h3c00;  // 1.0
    cam_near_clip = near_val;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    ok = 1'b1;
    for (int ph = 0; ph < N_PHASES && ok; ph++) begin
      @(posedge clk);
      near_val.fields.sign = 1'b0;  // only touched while idle
      near_val.fields.exp  = 5'(12 + $urandom % 4);
      near_val.fields.mant = 10'($urandom % 1024);
      cam_near_clip <= near_val;
      drive_phase(PHASE_CYCLES, ph == 0);  // first burst at full rate
      wait_idle(ok);
    end
    repeat (2) @(posedge clk);
    error_count += i_dut.i_proj_asserts.assert_fail_cnt;
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/proj_asserts.sv
`timescale 1ns/10ps
`default_nettype none
`include "proj_config.svh"

module proj_asserts (
  input wire                           clk,
  input wire                           arst_n,
  input wire                           vertex_valid,
  input wire                           pixel_valid,
  input wire [`PROJ_SCREEN_W_LOG2-1:0] pixel_x,
  input wire [`PROJ_SCREEN_H_LOG2-1:0] pixel_y
);

  localparam int LAT = `PROJ_DIV_LAT + `PROJ_MUL_LAT + `PROJ_VP_LAT;

  logic [LAT-1:0] vld_sr;  // input strobe delayed by the full latency
  int assert_fail_cnt = 0;  // read by the testbench at the end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[LAT-2:0], vertex_valid};
    end
  end

  // next edge after any reset edge, so during and right after reset
  rst_quiet: assert property (@(posedge clk) !arst_n |=> !pixel_valid)
    else begin
      assert_fail_cnt++;
      $error("pixel_valid high during or right after reset");
    end

  strobe_latency: assert property (@(posedge clk) disable iff (!arst_n)
                                   pixel_valid == vld_sr[LAT-1])
    else begin
      assert_fail_cnt++;
      $error("pixel_valid is not vertex_valid delayed by %0d cycles", LAT);
    end

  pixel_known: assert property (@(posedge clk) disable iff (!arst_n)
                                pixel_valid |-> !$isunknown({pixel_x, pixel_y}))
    else begin
      assert_fail_cnt++;
      $error("pixel_x or pixel_y unknown while pixel_valid is high");
    end

endmodule

bind proj_top proj_asserts i_proj_asserts (.*);

`default_nettype wire

//--- hdl/proj_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "proj_config.svh"

// vertex in, pixel out 6 clocks later
module proj_top (
  input  wire                           clk,
  input  wire                           arst_n,
  input  wire proj_pkg::f16                 cam_near_clip,
  input  wire                           vertex_valid,
  input  wire proj_pkg::vec3_f16            vertex,
  output logic                          pixel_valid,
  output logic [`PROJ_SCREEN_W_LOG2-1:0] pixel_x,
  output logic [`PROJ_SCREEN_H_LOG2-1:0] pixel_y,
  output logic                          off_screen,
  output logic                          behind
);

  screen_pt_if pt_if ();  // projection -> viewport

  vertex_project i_vertex_project (
    .clk           (clk),
    .arst_n        (arst_n),
    .cam_near_clip (cam_near_clip),
    .vertex_valid  (vertex_valid),
    .vertex        (vertex),
    .pt            (pt_if.src)
  );

  viewport_map i_viewport_map (
    .clk         (clk),
    .arst_n      (arst_n),
    .pt          (pt_if.dst),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .off_screen  (off_screen),
    .behind      (behind)
  );

endmodule

`default_nettype wire

//--- hdl/viewport_map.sv
`timescale 1ns/10ps
`default_nettype none
`include "proj_config.svh"

module viewport_map (
  input  wire                           clk,
  input  wire                           arst_n,
  screen_pt_if.dst                      pt,
  output logic                          pixel_valid,
  output logic [`PROJ_SCREEN_W_LOG2-1:0] pixel_x,
  output logic [`PROJ_SCREEN_H_LOG2-1:0] pixel_y,
  output logic                          off_screen,
  output logic                          behind
);
  import proj_pkg::*;

  int   px_c;
  int   py_c;
  logic off_x;
  logic off_y;

  // floor(c * 2^(lg-1)) + 2^(lg-1), clamped to 0..2^lg-1
  function automatic int map_axis(input f16 c, input int lg, output logic off);
    logic [10:0] sig;
    int          sh;
    int          mag;
    logic        frac_nz;
    int          scaled;
    int          pix;
    sig = {1'b1, c.fields.mant};
    sh  = 26 - lg - int'(c.fields.exp);  // value = sig * 2^(exp-25)
    if (c.fields.exp == 5'd0) begin
      scaled = 0;                           // flushed, lands on center
    end else if (c.fields.exp >= 5'd16) begin
      scaled = c.fields.sign ? -(1 << lg) : (1 << lg);  // |c| >= 2 or inf
    end else begin
      mag     = int'(sig >> sh);
      frac_nz = |(sig & ((11'd1 << sh) - 11'd1));
      scaled  = c.fields.sign ? -(mag + int'(frac_nz)) : mag;  // toward -inf
    end
    pix = scaled + (1 << (lg - 1));
    off = (pix < 0) || (pix > (1 << lg) - 1);
    if (pix < 0) begin
      pix = 0;
    end else if (pix > (1 << lg) - 1) begin
      pix = (1 << lg) - 1;                 // clamp to right / bottom edge
    end
    return pix;
  endfunction

  always_comb begin
    px_c = map_axis(pt.x, `PROJ_SCREEN_W_LOG2, off_x);
    py_c = map_axis(pt.y, `PROJ_SCREEN_H_LOG2, off_y);
  end

  // payload, sampled every cycle
  always_ff @(posedge clk) begin
    pixel_x    <= px_c[`PROJ_SCREEN_W_LOG2-1:0];
    pixel_y    <= py_c[`PROJ_SCREEN_H_LOG2-1:0];
    off_screen <= off_x | off_y;
    behind     <= pt.behind;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= pt.valid;
    end
  end

endmodule

`default_nettype wire

//--- hdl/vertex_project.sv
`timescale 1ns/10ps
`default_nettype none
`include "proj_config.svh"

module vertex_project (
  input  wire                clk,
  input  wire                arst_n,
  input  wire proj_pkg::f16      cam_near_clip,
  input  wire                vertex_valid,
  input  wire proj_pkg::vec3_f16 vertex,
  screen_pt_if.src           pt
);
  import proj_pkg::*;

  localparam int BEHIND_LAT = `PROJ_DIV_LAT + `PROJ_MUL_LAT;  // matches a lane

  f16   v_x;
  f16   v_y;
  f16   v_z;
  logic z_behind;
  logic [BEHIND_LAT-1:0] behind_sr;

  assign v_x = vertex[0];
  assign v_y = vertex[1];
  assign v_z = vertex[2];

  // z >= 0, or zero / subnormal z
  assign z_behind = ~v_z.fields.sign | (v_z.fields.exp == 5'd0);

  always_ff @(posedge clk) begin
    behind_sr <= {behind_sr[BEHIND_LAT-2:0], z_behind};
  end

  assign pt.behind = behind_sr[BEHIND_LAT-1];

  z_divide zd_x (
    .clk           (clk),
    .arst_n        (arst_n),
    .cam_near_clip (cam_near_clip),
    .coord         (v_x),
    .z_coord       (v_z),
    .in_valid      (vertex_valid),
    .screen_coord  (pt.x),
    .out_valid     (pt.valid)   // x lane strobe stands for both
  );

  // identical lane, its strobe is redundant
  z_divide zd_y (
    .clk           (clk),
    .arst_n        (arst_n),
    .cam_near_clip (cam_near_clip),
    .coord         (v_y),
    .z_coord       (v_z),
    .in_valid      (vertex_valid),
    .screen_coord  (pt.y),
    .out_valid     ()
  );

endmodule

`default_nettype wire

//--- hdl/z_divide.sv
`timescale 1ns/10ps
`default_nettype none

// screen = coord / -z * near, one lane
module z_divide (
  input  wire           clk,
  input  wire           arst_n,
  input  wire proj_pkg::f16 cam_near_clip,  // level, held while busy
  input  wire proj_pkg::f16 coord,
  input  wire proj_pkg::f16 z_coord,
  input  wire           in_valid,
  output proj_pkg::f16  screen_coord,
  output logic          out_valid
);
  import proj_pkg::*;

  f16   neg_z;
  f16   div_q;
  logic div_valid;

  // camera looks down -z, flip sign
  always_comb begin
    neg_z             = z_coord;
    neg_z.fields.sign = ~z_coord.fields.sign;
  end

  fp16_div f_div (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .a         (coord),
    .b         (neg_z),
    .out_valid (div_valid),
    .q         (div_q)
  );

  // near is stable so it goes in undelayed
  fp16_mul f_mul (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (div_valid),
    .a         (div_q),
    .b         (cam_near_clip),
    .out_valid (out_valid),
    .p         (screen_coord)
  );

endmodule

`default_nettype wire

//--- fp16/fp16_mul.sv
`timescale 1ns/10ps
`default_nettype none
`include "proj_config.svh"

module fp16_mul (
  input  wire           clk,
  input  wire           arst_n,
  input  wire           in_valid,
  input  wire proj_pkg::f16 a,
  input  wire proj_pkg::f16 b,
  output logic          out_valid,
  output proj_pkg::f16  p
);
  import proj_pkg::*;

  logic              s1_sign;
  logic              s1_zero;  // either operand zero or subnormal
  logic signed [6:0] s1_exp;   // biased sum, may leave 1..30
  logic [21:0]       s1_prod;  // 11 x 11 significands

  logic signed [6:0] n_exp;
  logic [9:0]        n_mant;

  logic [`PROJ_MUL_LAT-1:0] vld_sr;

  always_ff @(posedge clk) begin
    s1_sign <= a.fields.sign ^ b.fields.sign;
    s1_zero <= (a.fields.exp == 5'd0) || (b.fields.exp == 5'd0);
    s1_exp  <= $signed({2'b00, a.fields.exp}) + $signed({2'b00, b.fields.exp}) - F16_BIAS;
    s1_prod <= {1'b1, a.fields.mant} * {1'b1, b.fields.mant};
  end

  // product in [1, 4), one right shift at most
  always_comb begin
    n_exp  = s1_prod[21] ? s1_exp + 7'sd1 : s1_exp;
    n_mant = s1_prod[21] ? s1_prod[20:11] : s1_prod[19:10];  // truncate
  end

  always_ff @(posedge clk) begin
    if (s1_zero || n_exp <= 7'sd0) begin
      p <= f16_zero(s1_sign);  // zero wins, also flush
    end else if (n_exp >= 7'sd31) begin
      p <= f16_inf(s1_sign);
    end else begin
      p <= {s1_sign, n_exp[4:0], n_mant};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[`PROJ_MUL_LAT-2:0], in_valid};
    end
  end

  assign out_valid = vld_sr[`PROJ_MUL_LAT-1];

endmodule

`default_nettype wire

//--- fp16/fp16_div.sv
`timescale 1ns/10ps
`default_nettype none
`include "proj_config.svh"

module fp16_div (
  input  wire           clk,
  input  wire           arst_n,
  input  wire           in_valid,
  input  wire proj_pkg::f16 a,
  input  wire proj_pkg::f16 b,
  output logic          out_valid,
  output proj_pkg::f16  q
);
  import proj_pkg::*;

  // stage 1 regs
  logic              s1_sign;
  logic              s1_a_zero;  // dividend zero or subnormal
  logic              s1_b_zero;  // divisor zero or subnormal
  logic signed [6:0] s1_exp;     // biased exp difference
  logic [10:0]       s1_ma;
  logic [10:0]       s1_mb;

  // stage 2 regs
  logic              s2_sign;
  logic              s2_a_zero;
  logic              s2_b_zero;
  logic signed [6:0] s2_exp;
  logic [11:0]       s2_quo;

  logic [11:0]       quo_c;  // unrolled restoring divide
  logic [11:0]       rem_c;
  logic signed [6:0] n_exp;  // after normalize
  logic [9:0]        n_mant;

  logic [`PROJ_DIV_LAT-1:0] vld_sr;

  // unpack, sign, exponent difference
  always_ff @(posedge clk) begin
    s1_sign   <= a.fields.sign ^ b.fields.sign;
    s1_a_zero <= (a.fields.exp == 5'd0);
    s1_b_zero <= (b.fields.exp == 5'd0);
    s1_exp    <= $signed({2'b00, a.fields.exp}) - $signed({2'b00, b.fields.exp}) + F16_BIAS;
    s1_ma     <= {1'b1, a.fields.mant};  // hidden one
    s1_mb     <= {1'b1, b.fields.mant};
  end

  // ratio in (0.5, 2), 12 quotient bits, msb is the integer bit
  always_comb begin
    rem_c = {1'b0, s1_ma};
    for (int i = 11; i >= 0; i--) begin
      if (rem_c >= {1'b0, s1_mb}) begin
        quo_c[i] = 1'b1;
        rem_c    = rem_c - {1'b0, s1_mb};
      end else begin
        quo_c[i] = 1'b0;
      end
      rem_c = rem_c << 1;  // remainder < divisor so no carry out
    end
  end

  always_ff @(posedge clk) begin
    s2_sign   <= s1_sign;
    s2_a_zero <= s1_a_zero;
    s2_b_zero <= s1_b_zero;
    s2_exp    <= s1_exp;
    s2_quo    <= quo_c;
  end

  // at most one left shift, low bits simply dropped
  always_comb begin
    n_exp  = s2_quo[11] ? s2_exp : s2_exp - 7'sd1;
    n_mant = s2_quo[11] ? s2_quo[10:1] : s2_quo[9:0];
  end

  always_ff @(posedge clk) begin
    if (s2_b_zero) begin
      q <= f16_inf(s2_sign);                                  // x / 0
    end else if (s2_a_zero || n_exp <= 7'sd0) begin
      q <= f16_zero(s2_sign);                                 // zero or underflow
    end else if (n_exp >= 7'sd31) begin
      q <= f16_inf(s2_sign);                                  // overflow
    end else begin
      q <= {s2_sign, n_exp[4:0], n_mant};
    end
  end

  // valid follows the data stages
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[`PROJ_DIV_LAT-2:0], in_valid};
    end
  end

  assign out_valid = vld_sr[`PROJ_DIV_LAT-1];

endmodule

`default_nettype wire

//--- common/screen_pt_if.sv
`timescale 1ns/10ps
`default_nettype none

// one projected point, projection stage -> viewport stage
interface screen_pt_if;
  import proj_pkg::*;

  logic valid;   // one-cycle strobe, no ready
  f16   x;       // normalized screen x
  f16   y;       // normalized screen y
  logic behind;  // on or behind camera plane

  modport src (output valid, x, y, behind);
  modport dst (input  valid, x, y, behind);

endinterface

`default_nettype wire

//--- common/proj_pkg.sv
`default_nettype none

package proj_pkg;

  // half precision field view: 1 sign, 5 exp (bias 15), 10 mantissa
  typedef struct packed {
    logic       sign;
    logic [4:0] exp;
    logic [9:0] mant;
  } f16_fields;

  // same word, raw or decoded
  typedef union packed {
    logic [15:0] bits;
    f16_fields   fields;
  } f16;

  typedef f16 [2:0] vec3_f16;  // [0] x, [1] y, [2] z

  localparam logic signed [6:0] F16_BIAS    = 7'sd15;
  localparam logic [4:0]        F16_EXP_INF = 5'h1f;

  // signed zero, also the flush result
  function automatic f16 f16_zero(input logic sign);
    f16 r;
    r.bits        = '0;
    r.fields.sign = sign;
    return r;
  endfunction

  // signed infinity for overflow and x/0
  function automatic f16 f16_inf(input logic sign);
    f16 r;
    r.fields.sign = sign;
    r.fields.exp  = F16_EXP_INF;
    r.fields.mant = '0;
    return r;
  endfunction

endpackage

`default_nettype wire

//--- common/proj_config.svh
`ifndef PROJ_CONFIG_SVH
`define PROJ_CONFIG_SVH

// log2 sizes of a 64 x 64 screen
`define PROJ_SCREEN_W_LOG2 6
`define PROJ_SCREEN_H_LOG2 6

// per-block latencies in clocks
`define PROJ_DIV_LAT 3
`define PROJ_MUL_LAT 2
`define PROJ_VP_LAT  1

`endif
